// File: list.f
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_apb_regs.sv
uart_top.sv
tb_uart_assert.sv
tb_uart.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_uart
FILELIST  = list.f
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "test  - build and run the testbench with Verilator"
	@echo "clean - remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "FAIL: run ended early"; exit 1; }
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: tb_uart.sv
`timescale 1ns/1ps

module tb_uart;
    import uart_pkg::*;

    localparam int CLOCK_FREQ     = 1000000;
    localparam int BAUD_RATE      = 100000;
    localparam int FIFO_DEPTH     = 4;
    localparam int BIT_TIME       = CLOCK_FREQ / BAUD_RATE;  // 10 cycles per bit
    localparam int FRAME_CYCLES   = 10 * BIT_TIME;           // 8N1 frame
    localparam int FRAME_COUNT    = 16;                      // Frames over all tests
    // Frames plus APB polling and a wide margin
    localparam int TIMEOUT_CYCLES = (FRAME_COUNT * FRAME_CYCLES + 400) * 10;

    // STATUS bit positions
    localparam int FRAME_ERR_BIT  = 0;
    localparam int RX_OVERRUN_BIT = 1;
    localparam int RX_EMPTY_BIT   = 2;
    localparam int TX_BUSY_BIT    = 3;
    localparam int TX_EMPTY_BIT   = 4;
    localparam int TX_FULL_BIT    = 5;

    // Quiet UART with both FIFOs empty and no flag raised
    localparam apb_data_t IDLE_STATUS = (1 << TX_EMPTY_BIT) | (1 << RX_EMPTY_BIT);

    logic       clk;
    logic       rst;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       tx;
    logic       rx;
    logic       rx_direct_en;       // Line driven by the testbench instead of looped back
    logic       rx_direct;
    logic [31:0] rng_state;
    int         errors = 0;
    int         cycle_count = 0;
    uart_byte_t expected_q[$];      // Bytes still to be read back

    assign rx = rx_direct_en ? rx_direct : tx;  // Loopback mux

    uart_top #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_uart_top (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .tx, .rx
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, check errors: %0d", cycle_count, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_byte(output uart_byte_t b);
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
    endtask

    task automatic check_value(input string name, input apb_data_t expected,
                               input apb_data_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Setup then access phase with prdata taken mid-cycle
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic slverr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);                     // DUT takes the access here
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic      slverr;
        apb_transfer(1'b1, addr, data, rdata, slverr);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
        logic slverr;
        apb_transfer(1'b0, addr, '0, rdata, slverr);
    endtask

    // Poll STATUS until one bit reaches a level
    task automatic wait_status(input int bit_idx, input logic value);
        apb_data_t s;
        do begin
            apb_read(ADDR_STATUS, s);
        end while (s[bit_idx] !== value);
    endtask

    task automatic send_random(output uart_byte_t b);
        next_byte(b);
        apb_write(ADDR_DATA, apb_data_t'(b));
    endtask

    task automatic read_expect(input string name);
        apb_data_t  d;
        uart_byte_t exp;
        exp = expected_q.pop_front();
        apb_read(ADDR_DATA, d);
        check_value(name, apb_data_t'(exp), d);
    endtask

    // One 8N1 frame straight onto rx followed by two idle bit times
    task automatic drive_frame(input uart_byte_t b, input logic stop);
        logic [9:0] frame;
        frame = {stop, b, 1'b0};            // LSB goes out first
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_direct <= frame[i];
            repeat (BIT_TIME - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_direct <= 1'b1;
        repeat (2 * BIT_TIME) @(posedge clk);
    endtask

    initial begin
        apb_data_t  rd;
        logic       err;
        uart_byte_t b;
        int         sent;
        rst          <= 1'b1;
        psel         <= 1'b0;
        penable      <= 1'b0;
        pwrite       <= 1'b0;
        paddr        <= '0;
        pwdata       <= '0;
        rx_direct_en <= 1'b0;
        rx_direct    <= 1'b1;
        rng_state = 32'hb4894a8e;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // Reset state
        apb_read(ADDR_STATUS, rd);
        check_value("reset_status", IDLE_STATUS, rd);
        @(negedge clk);
        check_bit("reset_tx_line", 1'b1, tx);
        check_value("reset_prdata", '0, prdata);    // Idle bus reads zero
        check_bit("reset_pslverr", 1'b0, pslverr);

        // Single byte through the loopback
        send_random(b);
        expected_q.push_back(b);
        wait_status(RX_EMPTY_BIT, 1'b0);
        read_expect("loopback_byte");
        apb_read(ADDR_STATUS, rd);
        check_bit("loopback_rx_empty", 1'b1, rd[RX_EMPTY_BIT]);

        // Burst of eight drained as bytes land
        sent = 0;
        while (sent < 8 || expected_q.size() != 0) begin
            apb_read(ADDR_STATUS, rd);
            if (!rd[RX_EMPTY_BIT]) begin
                read_expect("burst_byte");
            end else if (sent < 8 && !rd[TX_FULL_BIT]) begin
                send_random(b);
                expected_q.push_back(b);
                sent++;
            end
        end

        // Five unread bytes where the last has no room
        for (int i = 0; i < 5; i++) begin
            wait_status(TX_FULL_BIT, 1'b0);
            send_random(b);
            if (i < FIFO_DEPTH) begin
                expected_q.push_back(b);
            end
        end
        wait_status(RX_OVERRUN_BIT, 1'b1);
        apb_read(ADDR_STATUS, rd);
        check_bit("overrun_rx_empty", 1'b0, rd[RX_EMPTY_BIT]);
        check_bit("overrun_frame_err", 1'b0, rd[FRAME_ERR_BIT]);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_expect("overrun_kept_byte");
        end
        apb_read(ADDR_DATA, rd);
        check_value("overrun_empty_read", '0, rd);
        apb_read(ADDR_STATUS, rd);
        check_bit("overrun_sticky", 1'b1, rd[RX_OVERRUN_BIT]);
        check_bit("overrun_drained", 1'b1, rd[RX_EMPTY_BIT]);
        apb_write(ADDR_STATUS, apb_data_t'(1 << RX_OVERRUN_BIT));  // Write one to clear
        apb_read(ADDR_STATUS, rd);
        check_bit("overrun_cleared", 1'b0, rd[RX_OVERRUN_BIT]);

        // Bad stop bit then a good frame on the directly driven line
        wait_status(TX_BUSY_BIT, 1'b0);
        repeat (2 * BIT_TIME) @(posedge clk);
        @(posedge clk);
        rx_direct    <= 1'b1;
        rx_direct_en <= 1'b1;
        next_byte(b);
        drive_frame(b, 1'b0);
        apb_read(ADDR_STATUS, rd);
        check_bit("bad_stop_frame_err", 1'b1, rd[FRAME_ERR_BIT]);
        check_bit("bad_stop_nothing_stored", 1'b1, rd[RX_EMPTY_BIT]);
        next_byte(b);
        expected_q.push_back(b);
        drive_frame(b, 1'b1);
        wait_status(RX_EMPTY_BIT, 1'b0);
        read_expect("good_after_bad");
        apb_write(ADDR_STATUS, apb_data_t'(1 << FRAME_ERR_BIT));
        apb_read(ADDR_STATUS, rd);
        check_bit("frame_err_cleared", 1'b0, rd[FRAME_ERR_BIT]);
        @(posedge clk);
        rx_direct_en <= 1'b0;

        // Unmapped offset where a write must not reach the TX FIFO
        apb_read(ADDR_STATUS, rd);
        check_value("unmapped_status_before", IDLE_STATUS, rd);
        apb_transfer(1'b0, 4'h8, '0, rd, err);
        check_bit("unmapped_read_slverr", 1'b1, err);
        check_value("unmapped_read_data", '0, rd);
        apb_transfer(1'b1, 4'h8, 32'h0000_00a5, rd, err);
        check_bit("unmapped_write_slverr", 1'b1, err);
        apb_read(ADDR_STATUS, rd);
        check_value("unmapped_status", IDLE_STATUS, rd);

        repeat (4) @(posedge clk);
        $display("check errors: %0d, assertion failures: %0d",
                 errors, i_uart_top.i_uart_assert.fail_count);
        if (errors == 0 && i_uart_top.i_uart_assert.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb_uart_assert.sv
`timescale 1ns/1ps

module uart_assert #(
    parameter int BIT_TIME
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 tx,
    input logic                 tx_busy,
    input logic                 tx_pop,
    input uart_pkg::uart_byte_t tx_rdata,
    input logic                 psel,
    input logic                 penable,
    input uart_pkg::apb_addr_t  paddr,
    input logic                 pready,
    input logic                 pslverr
);
    import uart_pkg::*;

    int unsigned fail_count = 0;    // Read by the testbench at the end
    int          start_cnt;         // Cycles into the start bit
    logic        in_start;
    logic        first_bit;         // Data bit 0 of the popped byte

    // Follow the start bit from the cycle after the pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_start  <= 1'b0;
            start_cnt <= 0;
            first_bit <= 1'b0;
        end else if (tx_pop) begin
            in_start  <= 1'b1;
            start_cnt <= 0;
            first_bit <= tx_rdata[0];
        end else if (in_start) begin
            in_start  <= (start_cnt < BIT_TIME);    // One cycle past the start bit
            start_cnt <= start_cnt + 1;
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while the serializer is idle");
        end

    a_start_low: assert property (@(posedge clk) disable iff (rst)
        in_start && start_cnt < BIT_TIME |-> !tx)
        else begin
            fail_count++;
            $error("start bit ended early");
        end

    a_start_len: assert property (@(posedge clk) disable iff (rst)
        in_start && start_cnt == BIT_TIME |-> tx == first_bit)
        else begin
            fail_count++;
            $error("line after the start bit is not data bit 0");
        end

    a_pready: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            fail_count++;
            $error("pready dropped");
        end

    a_slverr: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable && paddr != ADDR_DATA && paddr != ADDR_STATUS)
        else begin
            fail_count++;
            $error("pslverr on a mapped offset or outside an access");
        end

endmodule

bind uart_top uart_assert #(.BIT_TIME(CLOCK_FREQ / BAUD_RATE)) i_uart_assert (
    .clk      (clk),
    .rst      (rst),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_pop   (tx_pop),
    .tx_rdata (tx_rdata),
    .psel     (psel),
    .penable  (penable),
    .paddr    (paddr),
    .pready   (pready),
    .pslverr  (pslverr)
);

// File: uart_top.sv
`timescale 1ns/1ps

module uart_top #(
    parameter int CLOCK_FREQ = 50000000,
    parameter int BAUD_RATE  = 115200,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  uart_pkg::apb_addr_t paddr,
    input  uart_pkg::apb_data_t pwdata,
    output uart_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                tx,
    input  logic                rx
);
    import uart_pkg::*;

    // Transmit path
    logic       tx_push;
    uart_byte_t tx_wdata;
    logic       tx_pop;
    uart_byte_t tx_rdata;       // FIFO head into the serializer
    logic       tx_full;
    logic       tx_empty;
    logic       tx_busy;

    // Receive path
    rx_entry_t  rx_entry;
    logic       frame_err_pulse;
    logic       rx_push;
    uart_byte_t rx_wdata;
    logic       rx_pop;
    uart_byte_t rx_rdata;
    logic       rx_full;
    logic       rx_empty;

    uart_apb_regs i_regs (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .tx_push, .tx_wdata, .tx_full, .tx_empty, .tx_busy,
        .rx_pop, .rx_rdata, .rx_empty, .rx_full, .rx_entry,
        .rx_push, .rx_wdata, .frame_err_pulse
    );

    uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_tx_fifo (
        .clk, .rst,
        .push (tx_push),  .wdata (tx_wdata),
        .pop  (tx_pop),   .rdata (tx_rdata),
        .full (tx_full),  .empty (tx_empty)
    );

    uart_tx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) i_tx (
        .clk, .rst,
        .data (tx_rdata), .fifo_empty (tx_empty), .pop (tx_pop),
        .busy (tx_busy),  .tx
    );

    uart_rx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) i_rx (
        .clk, .rst,
        .rx, .entry (rx_entry), .frame_err (frame_err_pulse)
    );

    uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_rx_fifo (
        .clk, .rst,
        .push (rx_push),  .wdata (rx_wdata),
        .pop  (rx_pop),   .rdata (rx_rdata),
        .full (rx_full),  .empty (rx_empty)
    );

endmodule

// File: uart_apb_regs.sv
`timescale 1ns/1ps

module uart_apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  uart_pkg::apb_addr_t   paddr,
    input  uart_pkg::apb_data_t   pwdata,
    output uart_pkg::apb_data_t   prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Transmit FIFO side
    output logic                  tx_push,
    output uart_pkg::uart_byte_t  tx_wdata,
    input  logic                  tx_full,
    input  logic                  tx_empty,
    input  logic                  tx_busy,
    // Receive FIFO side
    output logic                  rx_pop,
    input  uart_pkg::uart_byte_t  rx_rdata,
    input  logic                  rx_empty,
    input  logic                  rx_full,
    input  uart_pkg::rx_entry_t   rx_entry,
    output logic                  rx_push,
    output uart_pkg::uart_byte_t  rx_wdata,
    input  logic                  frame_err_pulse
);
    import uart_pkg::*;

    logic         access;       // APB access phase
    logic         hit_data;
    logic         hit_status;
    logic         wr_status;
    uart_status_t clr_mask;     // Write-one-to-clear view of pwdata
    uart_status_t status;
    logic         rx_overrun;
    logic         frame_err;

    assign access     = psel && penable;
    assign hit_data   = (paddr == ADDR_DATA);
    assign hit_status = (paddr == ADDR_STATUS);
    assign wr_status  = access && pwrite && hit_status;
    assign clr_mask   = uart_status_t'(pwdata[5:0]);

    // Zero wait states, every access ends in its access phase
    assign pready  = 1'b1;
    assign pslverr = access && !hit_data && !hit_status;  // Unmapped offset

    // TX FIFO drops the byte itself when full
    assign tx_push  = access && pwrite && hit_data;
    assign tx_wdata = pwdata[7:0];

    // Reading DATA takes the head byte
    assign rx_pop = access && !pwrite && hit_data;

    // Incoming byte goes to the RX FIFO unless it has no room
    assign rx_push  = rx_entry.valid && !rx_full;
    assign rx_wdata = rx_entry.data;

    // Sticky flags, a new event wins over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            if (rx_entry.valid && rx_full) begin
                rx_overrun <= 1'b1;              // Byte lost
            end else if (wr_status && clr_mask.rx_overrun) begin
                rx_overrun <= 1'b0;
            end
            if (frame_err_pulse) begin
                frame_err <= 1'b1;
            end else if (wr_status && clr_mask.frame_err) begin
                frame_err <= 1'b0;
            end
        end
    end

    // Live status as seen in the access cycle
    always_comb begin
        status            = '0;
        status.tx_full    = tx_full;
        status.tx_empty   = tx_empty;
        status.tx_busy    = tx_busy;
        status.rx_empty   = rx_empty;
        status.rx_overrun = rx_overrun;
        status.frame_err  = frame_err;
    end

    // Read mux, zero outside a read
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                ADDR_DATA: begin
                    if (!rx_empty) begin
                        prdata = apb_data_t'(rx_rdata);   // Empty FIFO reads zero
                    end
                end
                ADDR_STATUS: prdata = apb_data_t'(status);
                default:     prdata = '0;
            endcase
        end
    end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLOCK_FREQ,
    parameter int BAUD_RATE
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx,
    output uart_pkg::rx_entry_t entry,
    output logic                frame_err
);
    import uart_pkg::*;

    localparam int BIT_TIME = CLOCK_FREQ / BAUD_RATE;
    localparam int HALF_BIT = BIT_TIME / 2;        // Start bit re-check point
    localparam int CNT_W    = $clog2(BIT_TIME + 1);

    typedef logic [CNT_W-1:0] bit_cnt_t;

    rx_state_t  state;
    logic       rx_meta;        // First sync flop
    logic       rx_sync;        // Usable line level
    logic       rx_last;        // Previous level, for edge detect
    bit_cnt_t   clk_cnt;
    logic [2:0] bit_idx;
    uart_byte_t shift_reg;
    logic       fall;
    logic       half_end;
    logic       bit_end;
    logic       stop_sample;

    assign fall        = rx_last && !rx_sync;
    assign half_end    = (clk_cnt == bit_cnt_t'(HALF_BIT - 1));
    assign bit_end     = (clk_cnt == bit_cnt_t'(BIT_TIME - 1));
    assign stop_sample = (state == RX_STOP) && bit_end;

    // Result in the cycle of the stop sample
    assign entry.valid = stop_sample && rx_sync;
    assign entry.data  = shift_reg;
    assign frame_err   = stop_sample && !rx_sync;   // Byte is dropped

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (fall) begin
                        state <= RX_START;      // Possible start bit
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        clk_cnt <= '0;          // Now at mid-bit
                        bit_idx <= '0;
                        // Glitch if the line is back high
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        state   <= RX_IDLE; // Waits for the next falling edge
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLOCK_FREQ,
    parameter int BAUD_RATE
) (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t data,        // Head of the TX FIFO
    input  logic                 fifo_empty,
    output logic                 pop,
    output logic                 busy,
    output logic                 tx
);
    import uart_pkg::*;

    localparam int BIT_TIME = CLOCK_FREQ / BAUD_RATE;   // Cycles per bit
    localparam int CNT_W    = $clog2(BIT_TIME + 1);

    typedef logic [CNT_W-1:0] bit_cnt_t;

    tx_state_t  state;
    bit_cnt_t   clk_cnt;    // Cycles into the current bit
    logic [2:0] bit_idx;    // Data bit on the line
    uart_byte_t shift_reg;
    logic       ready;
    logic       bit_end;

    assign ready   = (state == TX_IDLE);
    assign busy    = !ready;
    assign pop     = ready && !fifo_empty;          // Byte taken this cycle
    assign bit_end = (clk_cnt == bit_cnt_t'(BIT_TIME - 1));

    // Shift register, loaded on pop and shifted after each data bit
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= data;
        end else if (state == TX_DATA && bit_end) begin
            shift_reg <= {1'b0, shift_reg[7:1]};    // LSB first
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;                        // Line idles high
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (pop) begin
                        state <= TX_START;
                        tx    <= 1'b0;              // Start bit from next cycle
                    end
                end
                TX_START: if (bit_end) begin
                    state   <= TX_DATA;
                    bit_idx <= '0;
                    tx      <= shift_reg[0];
                end
                TX_DATA: if (bit_end) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= TX_STOP;
                        tx    <= 1'b1;              // Stop bit
                    end else begin
                        tx <= shift_reg[1];         // Next bit before the shift lands
                    end
                end
                TX_STOP: if (bit_end) begin
                    state <= TX_IDLE;               // Ready again next cycle
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
    parameter int FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  uart_pkg::uart_byte_t wdata,
    input  logic                 pop,
    output uart_pkg::uart_byte_t rdata,
    output logic                 full,
    output logic                 empty
);
    import uart_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    uart_byte_t mem [FIFO_DEPTH];   // Storage, no reset
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    count_t     count;              // Occupancy
    logic       do_push;
    logic       do_pop;

    assign full  = (count == count_t'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign do_push = push && !full;     // Push on full is dropped
    assign do_pop  = pop && !empty;     // Pop on empty does nothing

    // First word fall through
    assign rdata = mem[rd_ptr];

    // Wrap pointers explicitly so any depth works
    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

endmodule

// File: uart_pkg.sv
package uart_pkg;

    // Data widths with a meaning of their own
    typedef logic [7:0]  uart_byte_t;   // One character on the line
    typedef logic [3:0]  apb_addr_t;    // Register offset on APB
    typedef logic [31:0] apb_data_t;    // APB data word

    // Register map
    localparam apb_addr_t ADDR_DATA   = 4'h0;  // TX push on write, RX pop on read
    localparam apb_addr_t ADDR_STATUS = 4'h4;  // Status read, sticky clear on write

    // STATUS word, bit 5 down to bit 0
    typedef struct packed {
        logic tx_full;      // TX FIFO cannot take another byte
        logic tx_empty;     // Nothing waiting to be sent
        logic tx_busy;      // Serializer is in a frame
        logic rx_empty;     // Nothing to read back
        logic rx_overrun;   // Sticky, byte lost on a full RX FIFO
        logic frame_err;    // Sticky, stop bit was low
    } uart_status_t;

    // Received byte handed from the deserializer to the registers
    typedef struct packed {
        logic       valid;  // One cycle per good frame
        uart_byte_t data;
    } rx_entry_t;

    // Serializer FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Deserializer FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage
